/* common/tank_game_params.svh */
`ifndef TANK_GAME_PARAMS_SVH
`define TANK_GAME_PARAMS_SVH

`define SCREEN_W 160
`define SCREEN_H 120

`define TANK_W 8
`define TANK_H 16
`define GUN_W 4
`define GUN_H 2
`define GUN_DY 3
`define BULLET_W 4
`define BULLET_H 2

`define P1_START_X 144
`define P1_START_Y 50
`define P1_MIN_X 123
`define P1_MAX_X 144
`define P2_START_X 8
`define P2_START_Y 50
`define P2_MIN_X 8
`define P2_MAX_X 30
`define TANK_MIN_Y 10
`define TANK_MAX_Y 100
`define BULLET_FAR 150

`define COL_BLACK 0
`define COL_P1 3
`define COL_P2 1
`define COL_HIT 5

`define WIN_SCORE 8
`define FRAME_CYCLES 833334

`endif

/* common/tank_game_pkg.sv */
`default_nettype none

package tank_game_pkg;

	typedef logic [7:0] coord_t;
	typedef logic [14:0] pix_adr_t;	// y in [14:8], x in [7:0]
	typedef logic [2:0] colour_t;
	typedef logic [3:0] score_t;
	typedef logic [6:0] segs_t;	// Active low, segment g on bit 6

	typedef enum logic {
		P1,	// Right side, fires toward x 0
		P2	// Left side
	} player_e;

	// Frame sequencer states
	typedef enum logic [2:0] {
		ST_CLEAR,
		ST_DRAW,
		ST_IDLE,
		ST_ERASE,
		ST_STEP,
		ST_JUDGE,
		ST_SETTLE,
		ST_RESTART
	} ctrl_state_e;

endpackage

`default_nettype wire

/* hw/frame_tick.sv */
`default_nettype none
`include "tank_game_params.svh"

module frame_tick #(
	parameter int frame_cycles = `FRAME_CYCLES
) (
	input wire CLOCK_50,
	input wire rst_n,
	output logic frame
);
	localparam int cnt_w = $clog2(frame_cycles + 1);

	logic [cnt_w-1:0] cnt;

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= cnt_w'(frame_cycles - 1);
			frame <= 1'b0;
		end else begin
			frame <= (cnt == '0);
			cnt <= (cnt == '0) ? cnt_w'(frame_cycles - 1) : cnt - 1'b1;	// Period is frame_cycles
		end
	end

endmodule

`default_nettype wire

/* hw/seg7_decoder.sv */
`default_nettype none

module seg7_decoder (
	input wire tank_game_pkg::score_t digit,
	output tank_game_pkg::segs_t segs
);
	// Segments gfedcba, a lit segment is 0
	localparam tank_game_pkg::segs_t seg_table [16] = '{
		7'b100_0000,	// 0
		7'b111_1001,
		7'b010_0100,
		7'b011_0000,
		7'b001_1001,
		7'b001_0010,
		7'b000_0010,
		7'b111_1000,
		7'b000_0000,	// 8
		7'b001_1000,
		7'b000_1000,
		7'b000_0011,
		7'b100_0110,
		7'b010_0001,
		7'b000_0110,
		7'b000_1110	// F
	};

	assign segs = seg_table[digit];

endmodule

`default_nettype wire

/* game/player_unit.sv */
`default_nettype none
`include "tank_game_params.svh"

module player_unit #(
	parameter tank_game_pkg::player_e player = tank_game_pkg::P1
) (
	input wire CLOCK_50,
	input wire rst_n,
	input wire restart,
	input wire step,
	input wire reload,
	input wire up,
	input wire down,
	input wire left,
	input wire right,
	input wire fire,
	output tank_game_pkg::coord_t tank_x,
	output tank_game_pkg::coord_t tank_y,
	output tank_game_pkg::coord_t bullet_x,
	output tank_game_pkg::coord_t bullet_y,
	output logic fired
);
	localparam bit is_p1 = (player == tank_game_pkg::P1);
	localparam tank_game_pkg::coord_t start_x = is_p1 ? `P1_START_X : `P2_START_X;
	localparam tank_game_pkg::coord_t start_y = is_p1 ? `P1_START_Y : `P2_START_Y;
	localparam tank_game_pkg::coord_t min_x = is_p1 ? `P1_MIN_X : `P2_MIN_X;
	localparam tank_game_pkg::coord_t max_x = is_p1 ? `P1_MAX_X : `P2_MAX_X;
	localparam tank_game_pkg::coord_t far_x = is_p1 ? 0 : `BULLET_FAR;
	localparam tank_game_pkg::coord_t gun_dy = `GUN_DY;

	tank_game_pkg::coord_t nx, ny;

	// P1 gun sits left of the tank, P2 gun right of it
	function automatic tank_game_pkg::coord_t gun_x_of(input tank_game_pkg::coord_t tx);
		return is_p1 ? tx - 8'(`GUN_W) : tx + 8'(`TANK_W);
	endfunction

	function automatic tank_game_pkg::coord_t advance(input tank_game_pkg::coord_t bx);
		return is_p1 ? bx - 8'd1 : bx + 8'd1;
	endfunction

	always_comb begin
		nx = tank_x;
		ny = tank_y;
		if (left && tank_x > min_x)
			nx = nx - 8'd1;
		if (right && tank_x < max_x)
			nx = nx + 8'd1;
		if (up && tank_y > 8'(`TANK_MIN_Y))
			ny = ny - 8'd1;
		if (down && tank_y < 8'(`TANK_MAX_Y))
			ny = ny + 8'd1;
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			tank_x <= start_x;
			tank_y <= start_y;
			bullet_x <= gun_x_of(start_x);
			bullet_y <= start_y + gun_dy;
			fired <= 1'b0;
		end else if (restart) begin
			tank_x <= start_x;
			tank_y <= start_y;
			bullet_x <= gun_x_of(start_x);
			bullet_y <= start_y + gun_dy;
			fired <= 1'b0;
		end else if (reload) begin	// Bullet hit the other tank
			bullet_x <= gun_x_of(tank_x);
			bullet_y <= tank_y + gun_dy;
			fired <= 1'b0;
		end else if (step) begin
			tank_x <= nx;
			tank_y <= ny;
			if (!fired) begin
				bullet_x <= fire ? advance(gun_x_of(nx)) : gun_x_of(nx);
				bullet_y <= ny + gun_dy;
				fired <= fire;
			end else if (bullet_x == far_x) begin	// Missed, back to the gun
				bullet_x <= gun_x_of(nx);
				bullet_y <= ny + gun_dy;
				fired <= 1'b0;
			end else
				bullet_x <= advance(bullet_x);
		end
	end

endmodule

`default_nettype wire

/* game/score_keeper.sv */
`default_nettype none
`include "tank_game_params.svh"

module score_keeper (
	input wire CLOCK_50,
	input wire rst_n,
	input wire restart,
	input wire judge,
	input wire tank_game_pkg::coord_t p1_tank_x,
	input wire tank_game_pkg::coord_t p1_tank_y,
	input wire tank_game_pkg::coord_t p2_tank_x,
	input wire tank_game_pkg::coord_t p2_tank_y,
	input wire tank_game_pkg::coord_t p1_bullet_x,
	input wire tank_game_pkg::coord_t p1_bullet_y,
	input wire tank_game_pkg::coord_t p2_bullet_x,
	input wire tank_game_pkg::coord_t p2_bullet_y,
	input wire p1_fired,
	input wire p2_fired,
	output logic p1_reload,
	output logic p2_reload,
	output logic p1_hit,
	output logic p2_hit,
	output tank_game_pkg::score_t score_a,
	output tank_game_pkg::score_t score_b,
	output logic match_over
);
	logic hit_on_p1, hit_on_p2;

	// Bullet box against tank box
	function automatic logic overlap(input tank_game_pkg::coord_t bx, by, tx, ty);
		return (bx < tx + `TANK_W) && (bx + `BULLET_W > tx) &&
			(by < ty + `TANK_H) && (by + `BULLET_H > ty);
	endfunction

	assign hit_on_p1 = p2_fired && overlap(p2_bullet_x, p2_bullet_y, p1_tank_x, p1_tank_y);
	assign hit_on_p2 = p1_fired && overlap(p1_bullet_x, p1_bullet_y, p2_tank_x, p2_tank_y);
	assign match_over = (score_a == 4'(`WIN_SCORE)) || (score_b == 4'(`WIN_SCORE));

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			{p1_reload, p2_reload, p1_hit, p2_hit} <= '0;
			score_a <= '0;
			score_b <= '0;
		end else begin
			p1_reload <= judge && !restart && hit_on_p2;	// Shooter reloads
			p2_reload <= judge && !restart && hit_on_p1;
			if (restart) begin
				p1_hit <= 1'b0;
				p2_hit <= 1'b0;
				score_a <= '0;
				score_b <= '0;
			end else if (judge) begin
				p1_hit <= hit_on_p1;
				p2_hit <= hit_on_p2;
				score_a <= score_a + 4'(hit_on_p2);
				score_b <= score_b + 4'(hit_on_p1);
			end
		end
	end

endmodule

`default_nettype wire

/* game/game_control.sv */
`default_nettype none
`include "tank_game_params.svh"

module game_control (
	input wire CLOCK_50,
	input wire rst_n,
	input wire frame,
	input wire done,
	input wire match_over,
	input wire p1_hit,
	input wire p2_hit,
	input wire tank_game_pkg::coord_t p1_tank_x,
	input wire tank_game_pkg::coord_t p1_tank_y,
	input wire tank_game_pkg::coord_t p2_tank_x,
	input wire tank_game_pkg::coord_t p2_tank_y,
	input wire tank_game_pkg::coord_t p1_bullet_x,
	input wire tank_game_pkg::coord_t p1_bullet_y,
	input wire tank_game_pkg::coord_t p2_bullet_x,
	input wire tank_game_pkg::coord_t p2_bullet_y,
	output logic start,
	output tank_game_pkg::coord_t org_x,
	output tank_game_pkg::coord_t org_y,
	output tank_game_pkg::coord_t width,
	output tank_game_pkg::coord_t height,
	output tank_game_pkg::colour_t colour,
	output logic step,
	output logic judge,
	output logic restart
);
	localparam logic [2:0] last_sprite = 3'd5;

	tank_game_pkg::ctrl_state_e state;
	logic [2:0] idx;	// P1 tank, gun, bullet, then P2
	logic busy;	// Waiting on the filler
	logic fill;

	assign fill = (state == tank_game_pkg::ST_CLEAR) || (state == tank_game_pkg::ST_ERASE) ||
		(state == tank_game_pkg::ST_DRAW);
	assign start = fill && !busy;
	assign step = (state == tank_game_pkg::ST_STEP);
	assign judge = (state == tank_game_pkg::ST_JUDGE);
	assign restart = (state == tank_game_pkg::ST_RESTART);

	always_comb begin
		org_x = p1_tank_x;
		org_y = p1_tank_y;
		width = 8'(`TANK_W);
		height = 8'(`TANK_H);
		colour = p1_hit ? 3'(`COL_HIT) : 3'(`COL_P1);
		case (idx)
			3'd1: {org_x, org_y, width, height, colour} = {p1_tank_x - 8'(`GUN_W),
				p1_tank_y + 8'(`GUN_DY), 8'(`GUN_W), 8'(`GUN_H), 3'(`COL_P1)};
			3'd2: {org_x, org_y, width, height, colour} = {p1_bullet_x, p1_bullet_y,
				8'(`BULLET_W), 8'(`BULLET_H), 3'(`COL_P1)};
			3'd3: {org_x, org_y, colour} = {p2_tank_x, p2_tank_y,
				p2_hit ? 3'(`COL_HIT) : 3'(`COL_P2)};
			3'd4: {org_x, org_y, width, height, colour} = {p2_tank_x + 8'(`TANK_W),
				p2_tank_y + 8'(`GUN_DY), 8'(`GUN_W), 8'(`GUN_H), 3'(`COL_P2)};
			3'd5: {org_x, org_y, width, height, colour} = {p2_bullet_x, p2_bullet_y,
				8'(`BULLET_W), 8'(`BULLET_H), 3'(`COL_P2)};
			default: ;
		endcase
		if (state == tank_game_pkg::ST_CLEAR)
			{org_x, org_y, width, height} = {8'd0, 8'd0, 8'(`SCREEN_W), 8'(`SCREEN_H)};
		if (state != tank_game_pkg::ST_DRAW)
			colour = 3'(`COL_BLACK);	// Clear and erase
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= tank_game_pkg::ST_CLEAR;
			idx <= '0;
			busy <= 1'b0;
		end else begin
			if (start)
				busy <= 1'b1;
			if (fill && done) begin
				busy <= 1'b0;
				idx <= (state == tank_game_pkg::ST_CLEAR || idx == last_sprite) ? 3'd0 : idx + 3'd1;
			end
			case (state)
				tank_game_pkg::ST_CLEAR:
					if (done)
						state <= tank_game_pkg::ST_DRAW;
				tank_game_pkg::ST_DRAW:
					if (done && idx == last_sprite)
						state <= match_over ? tank_game_pkg::ST_RESTART : tank_game_pkg::ST_IDLE;
				tank_game_pkg::ST_IDLE:
					if (frame)
						state <= tank_game_pkg::ST_ERASE;
				tank_game_pkg::ST_ERASE:
					if (done && idx == last_sprite)
						state <= tank_game_pkg::ST_STEP;
				tank_game_pkg::ST_STEP: state <= tank_game_pkg::ST_JUDGE;
				tank_game_pkg::ST_JUDGE: state <= tank_game_pkg::ST_SETTLE;
				tank_game_pkg::ST_SETTLE: state <= tank_game_pkg::ST_DRAW;	// Reload lands
				default: state <= tank_game_pkg::ST_CLEAR;
			endcase
		end
	end

endmodule

`default_nettype wire

/* video/rect_filler.sv */
`default_nettype none

module rect_filler (
	input wire CLOCK_50,
	input wire rst_n,
	input wire start,
	input wire tank_game_pkg::coord_t org_x,
	input wire tank_game_pkg::coord_t org_y,
	input wire tank_game_pkg::coord_t width,
	input wire tank_game_pkg::coord_t height,
	input wire tank_game_pkg::colour_t colour,
	input wire wb_ack,
	output logic done,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output tank_game_pkg::pix_adr_t wb_adr,
	output tank_game_pkg::colour_t wb_dat
);
	tank_game_pkg::coord_t cur_x, cur_y, left_x, last_x, last_y;
	logic active;
	logic last_pix;

	assign wb_cyc = active;
	assign wb_stb = active;
	assign wb_we = active;
	assign wb_adr = {cur_y[6:0], cur_x};
	assign last_pix = (cur_x == last_x) && (cur_y == last_y);

	always_ff @(posedge CLOCK_50 or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= active && wb_ack && last_pix;
			if (start && !active)
				active <= 1'b1;
			else if (wb_ack && last_pix)
				active <= 1'b0;	// Cycle ends after the last pixel
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (start && !active) begin
			cur_x <= org_x;
			cur_y <= org_y;
			left_x <= org_x;
			last_x <= org_x + width - 8'd1;
			last_y <= org_y + height - 8'd1;
			wb_dat <= colour;
		end else if (active && wb_ack) begin
			cur_x <= (cur_x == last_x) ? left_x : cur_x + 8'd1;	// x runs fastest
			if (cur_x == last_x)
				cur_y <= cur_y + 8'd1;
		end
	end

endmodule

`default_nettype wire

/* hw/tank_game_top.sv */
`default_nettype none
`include "tank_game_params.svh"

module tank_game_top #(
	parameter int frame_cycles = `FRAME_CYCLES
) (
	input wire CLOCK_50,
	input wire rst_n,
	input wire p1_up,
	input wire p1_down,
	input wire p1_left,
	input wire p1_right,
	input wire p1_fire,
	input wire p2_up,
	input wire p2_down,
	input wire p2_left,
	input wire p2_right,
	input wire p2_fire,
	input wire wb_ack,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output tank_game_pkg::pix_adr_t wb_adr,
	output tank_game_pkg::colour_t wb_dat,
	output tank_game_pkg::segs_t hex0,
	output tank_game_pkg::segs_t hex1
);
	logic frame, start, done, step, judge, restart, match_over;
	logic p1_hit, p2_hit, p1_reload, p2_reload, p1_fired, p2_fired;
	tank_game_pkg::coord_t p1_tank_x, p1_tank_y, p1_bullet_x, p1_bullet_y;
	tank_game_pkg::coord_t p2_tank_x, p2_tank_y, p2_bullet_x, p2_bullet_y;
	tank_game_pkg::coord_t org_x, org_y, width, height;
	tank_game_pkg::colour_t colour;
	tank_game_pkg::score_t score_a, score_b;

	frame_tick #(.frame_cycles(frame_cycles)) tick0 (.CLOCK_50, .rst_n, .frame);

	player_unit #(.player(tank_game_pkg::P1)) p1_unit (
		.CLOCK_50, .rst_n, .restart, .step, .reload(p1_reload),
		.up(p1_up), .down(p1_down), .left(p1_left), .right(p1_right), .fire(p1_fire),
		.tank_x(p1_tank_x), .tank_y(p1_tank_y),
		.bullet_x(p1_bullet_x), .bullet_y(p1_bullet_y), .fired(p1_fired)
	);

	player_unit #(.player(tank_game_pkg::P2)) p2_unit (
		.CLOCK_50, .rst_n, .restart, .step, .reload(p2_reload),
		.up(p2_up), .down(p2_down), .left(p2_left), .right(p2_right), .fire(p2_fire),
		.tank_x(p2_tank_x), .tank_y(p2_tank_y),
		.bullet_x(p2_bullet_x), .bullet_y(p2_bullet_y), .fired(p2_fired)
	);

	score_keeper score0 (
		.CLOCK_50, .rst_n, .restart, .judge,
		.p1_tank_x, .p1_tank_y, .p2_tank_x, .p2_tank_y,
		.p1_bullet_x, .p1_bullet_y, .p2_bullet_x, .p2_bullet_y, .p1_fired, .p2_fired,
		.p1_reload, .p2_reload, .p1_hit, .p2_hit, .score_a, .score_b, .match_over
	);

	game_control ctrl0 (
		.CLOCK_50, .rst_n, .frame, .done, .match_over, .p1_hit, .p2_hit,
		.p1_tank_x, .p1_tank_y, .p2_tank_x, .p2_tank_y,
		.p1_bullet_x, .p1_bullet_y, .p2_bullet_x, .p2_bullet_y,
		.start, .org_x, .org_y, .width, .height, .colour, .step, .judge, .restart
	);

	rect_filler filler0 (
		.CLOCK_50, .rst_n, .start, .org_x, .org_y, .width, .height, .colour, .wb_ack,
		.done, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat
	);

	seg7_decoder hex0_dec (.digit(score_a), .segs(hex0));	// P1 score
	seg7_decoder hex1_dec (.digit(score_b), .segs(hex1));	// P2 score

endmodule

`default_nettype wire

/* verif/tank_game_checker.sv */
`default_nettype none
`include "tank_game_params.svh"

module tank_game_checker (
	input wire CLOCK_50,
	input wire rst_n,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire wb_ack,
	input wire tank_game_pkg::pix_adr_t wb_adr,
	input wire tank_game_pkg::colour_t wb_dat
);
	timeunit 1ns;
	timeprecision 1ps;

	bit stb_err, hold_err, range_err;
	logic failed;	// Any assertion has failed

	assign failed = stb_err || hold_err || range_err;

	a_stb_in_cycle: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		wb_stb |-> wb_cyc && wb_we)
		else begin
			$error("Wishbone strobe without cycle or write enable");
			stb_err = 1'b1;
		end

	// Master holds the write until the slave acks
	a_hold: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat))
		else begin
			$error("Wishbone address or data changed before ack");
			hold_err = 1'b1;
		end

	a_on_screen: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		wb_stb |-> wb_adr[7:0] < `SCREEN_W && wb_adr[14:8] < `SCREEN_H)
		else begin
			$error("Pixel address outside the screen");
			range_err = 1'b1;
		end

endmodule

bind rect_filler tank_game_checker chk0 (
	.CLOCK_50, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_ack, .wb_adr, .wb_dat
);

`default_nettype wire

/* verif/tank_game_tb.sv */
`default_nettype none
`include "tank_game_params.svh"

module tank_game_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int frame_cyc = 3000;
	localparam int clear_cyc = `SCREEN_W * `SCREEN_H * 4;

	logic CLOCK_50, rst_n, wb_ack;
	logic [4:0] in1, in2;	// up, down, left, right, fire
	logic wb_cyc, wb_stb, wb_we;
	tank_game_pkg::pix_adr_t wb_adr;
	tank_game_pkg::colour_t wb_dat;
	tank_game_pkg::segs_t hex0, hex1;

	// Scenario table
	string sc_name [$];
	logic [4:0] sc_in1 [$], sc_in2 [$];
	int sc_frames [$], sc_p1x [$], sc_p1y [$], sc_p2x [$], sc_p2y [$], sc_sa [$], sc_sb [$];

	// Reference model, index 0 is P1
	int tx [2], ty [2], bx [2], by [2], score [2];
	bit fired [2], hit [2];

	tank_game_pkg::pix_adr_t adr_q [$];
	tank_game_pkg::colour_t dat_q [$];
	string cur_name;
	int ack_wait, cycles, limit;

	tank_game_top #(.frame_cycles(frame_cyc)) dut0 (
		.CLOCK_50, .rst_n,
		.p1_up(in1[4]), .p1_down(in1[3]), .p1_left(in1[2]), .p1_right(in1[1]), .p1_fire(in1[0]),
		.p2_up(in2[4]), .p2_down(in2[3]), .p2_left(in2[2]), .p2_right(in2[1]), .p2_fire(in2[0]),
		.wb_ack, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat, .hex0, .hex1
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	// Framebuffer side, random ack delay
	always @(posedge CLOCK_50)
		if (wb_cyc && wb_stb && wb_ack) begin
			if (wb_we !== 1'b1)
				report_mismatch("wb_we", 1, wb_we);
			adr_q.push_back(wb_adr);
			dat_q.push_back(wb_dat);
			ack_wait = $urandom_range(2, 0);
		end

	always @(negedge CLOCK_50)
		if (!wb_stb)
			wb_ack = 1'b0;
		else if (ack_wait == 0)
			wb_ack = 1'b1;
		else begin
			wb_ack = 1'b0;
			ack_wait = ack_wait - 1;
		end

	always @(negedge CLOCK_50)
		if (dut0.filler0.chk0.failed) begin
			$display("A Wishbone assertion in the bound checker failed");
			$display("Test FAILED");
			$fatal(1);
		end

	always @(posedge CLOCK_50) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout: the DUT stopped writing pixels within %0d cycles", limit);
			$display("Test FAILED");
			$fatal(1);
		end
	end

	task automatic report_mismatch(input string what, input int exp, input int act);
		$display("MISMATCH %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_coord(input string what, input tank_game_pkg::coord_t exp,
		input tank_game_pkg::coord_t act);
		if (exp !== act)
			report_mismatch(what, exp, act);
	endtask

	task automatic check_colour(input string what, input tank_game_pkg::colour_t exp,
		input tank_game_pkg::colour_t act);
		if (exp !== act)
			report_mismatch(what, exp, act);
	endtask

	task automatic check_score(input string what, input tank_game_pkg::score_t exp,
		input tank_game_pkg::score_t act);
		if (exp !== act)
			report_mismatch(what, exp, act);
	endtask

	task automatic check_segs(input string what, input tank_game_pkg::segs_t exp,
		input tank_game_pkg::segs_t act);
		if (exp !== act)
			report_mismatch(what, exp, act);
	endtask

	function automatic tank_game_pkg::segs_t digit_segs(input int v);
		case (v)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			default: return 7'b0011000;
		endcase
	endfunction

	function automatic int gun_x(input int p, input int x);
		return p ? x + `TANK_W : x - `GUN_W;
	endfunction

	function automatic bit overlap(input int bxx, byy, txx, tyy);
		return bxx < txx + `TANK_W && bxx + `BULLET_W > txx &&
			byy < tyy + `TANK_H && byy + `BULLET_H > tyy;
	endfunction

	task automatic add_scenario(input string name, input logic [4:0] a, b, input int n,
		input int p1x, p1y, p2x, p2y, sa, sb);
		sc_name.push_back(name);
		sc_in1.push_back(a);
		sc_in2.push_back(b);
		sc_frames.push_back(n);
		sc_p1x.push_back(p1x);
		sc_p1y.push_back(p1y);
		sc_p2x.push_back(p2x);
		sc_p2y.push_back(p2y);
		sc_sa.push_back(sa);
		sc_sb.push_back(sb);
	endtask

	task automatic reset_model();
		tx = '{`P1_START_X, `P2_START_X};
		ty = '{`P1_START_Y, `P2_START_Y};
		for (int p = 0; p < 2; p++) begin
			bx[p] = gun_x(p, tx[p]);
			by[p] = ty[p] + `GUN_DY;
			fired[p] = 0;
			hit[p] = 0;
			score[p] = 0;
		end
	endtask

	task automatic step_model(input int p, input logic [4:0] in);
		int nx, ny, dir, far;
		nx = tx[p];
		ny = ty[p];
		dir = p ? 1 : -1;
		far = p ? `BULLET_FAR : 0;
		if (in[2] && tx[p] > (p ? `P2_MIN_X : `P1_MIN_X))
			nx = nx - 1;
		if (in[1] && tx[p] < (p ? `P2_MAX_X : `P1_MAX_X))
			nx = nx + 1;
		if (in[4] && ty[p] > `TANK_MIN_Y)
			ny = ny - 1;
		if (in[3] && ty[p] < `TANK_MAX_Y)
			ny = ny + 1;
		if (!fired[p] || bx[p] == far) begin
			bx[p] = gun_x(p, nx) + ((!fired[p] && in[0]) ? dir : 0);
			by[p] = ny + `GUN_DY;
			fired[p] = !fired[p] && in[0];
		end else
			bx[p] = bx[p] + dir;
		tx[p] = nx;
		ty[p] = ny;
	endtask

	task automatic judge_model();
		bit on_p1, on_p2;
		on_p1 = fired[1] && overlap(bx[1], by[1], tx[0], ty[0]);
		on_p2 = fired[0] && overlap(bx[0], by[0], tx[1], ty[1]);
		hit = '{on_p1, on_p2};
		score[0] = score[0] + on_p2;
		score[1] = score[1] + on_p1;
		for (int p = 0; p < 2; p++)
			if (p ? on_p1 : on_p2) begin	// Shooter reloads
				bx[p] = gun_x(p, tx[p]);
				by[p] = ty[p] + `GUN_DY;
				fired[p] = 0;
			end
	endtask

	task automatic expect_rect(input string what, input int x, y, w, h, input int col);
		tank_game_pkg::pix_adr_t a;
		tank_game_pkg::colour_t d;
		for (int r = 0; r < h; r++)
			for (int c = 0; c < w; c++) begin
				while (adr_q.size() == 0)
					@(posedge CLOCK_50);
				a = adr_q.pop_front();
				d = dat_q.pop_front();
				check_coord({what, " x"}, 8'(x + c), a[7:0]);
				check_coord({what, " y"}, 8'(y + r), {1'b0, a[14:8]});
				check_colour({what, " colour"}, 3'(col), d);
			end
	endtask

	task automatic expect_sprites(input bit erase);
		expect_rect("p1 tank", tx[0], ty[0], `TANK_W, `TANK_H,
			erase ? `COL_BLACK : (hit[0] ? `COL_HIT : `COL_P1));
		expect_rect("p1 gun", gun_x(0, tx[0]), ty[0] + `GUN_DY, `GUN_W, `GUN_H,
			erase ? `COL_BLACK : `COL_P1);
		expect_rect("p1 bullet", bx[0], by[0], `BULLET_W, `BULLET_H, erase ? `COL_BLACK : `COL_P1);
		expect_rect("p2 tank", tx[1], ty[1], `TANK_W, `TANK_H,
			erase ? `COL_BLACK : (hit[1] ? `COL_HIT : `COL_P2));
		expect_rect("p2 gun", gun_x(1, tx[1]), ty[1] + `GUN_DY, `GUN_W, `GUN_H,
			erase ? `COL_BLACK : `COL_P2);
		expect_rect("p2 bullet", bx[1], by[1], `BULLET_W, `BULLET_H, erase ? `COL_BLACK : `COL_P2);
	endtask

	task automatic expect_match_start();
		reset_model();
		expect_rect("clear", 0, 0, `SCREEN_W, `SCREEN_H, `COL_BLACK);
		expect_sprites(0);
	endtask

	initial begin
		int total;
		void'($urandom(32'h5bfb));
		{in1, in2, wb_ack, rst_n} = '0;
		cycles = 0;
		limit = 0;
		ack_wait = 0;
		cur_name = "reset";
		add_scenario("move_bounds", 5'b10100, 5'b01010, 30, 123, 20, 30, 80, 0, 0);
		add_scenario("y_limits", 5'b10000, 5'b01000, 20, 123, 10, 30, 100, 0, 0);
		add_scenario("fire_once", 5'b00001, 5'b00000, 1, 123, 10, 30, 100, 0, 0);
		add_scenario("miss_fly", 5'b00000, 5'b00000, 125, 123, 10, 30, 100, 0, 0);
		add_scenario("p2_align", 5'b00000, 5'b10000, 90, 123, 10, 30, 10, 0, 0);
		add_scenario("trade", 5'b00001, 5'b00001, 82, 123, 10, 30, 10, 1, 1);
		add_scenario("p1_three", 5'b00001, 5'b00000, 246, 123, 10, 30, 10, 4, 1);
		add_scenario("p1_wins", 5'b00001, 5'b00000, 328, 144, 50, 8, 50, 0, 0);
		total = 0;
		foreach (sc_frames[i])
			total = total + sc_frames[i];
		limit = (total + 2) * frame_cyc + 2 * clear_cyc + 10000;
		repeat (3) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		rst_n = 1'b1;
		expect_match_start();
		foreach (sc_name[i]) begin
			cur_name = sc_name[i];
			@(negedge CLOCK_50);
			in1 = sc_in1[i];
			in2 = sc_in2[i];
			for (int f = 0; f < sc_frames[i]; f++) begin
				expect_sprites(1);
				step_model(0, sc_in1[i]);
				step_model(1, sc_in2[i]);
				judge_model();
				expect_sprites(0);
				if (score[0] == `WIN_SCORE || score[1] == `WIN_SCORE)
					expect_match_start();
			end
			check_coord("p1 tank x", 8'(sc_p1x[i]), 8'(tx[0]));
			check_coord("p1 tank y", 8'(sc_p1y[i]), 8'(ty[0]));
			check_coord("p2 tank x", 8'(sc_p2x[i]), 8'(tx[1]));
			check_coord("p2 tank y", 8'(sc_p2y[i]), 8'(ty[1]));
			check_score("model score a", 4'(sc_sa[i]), 4'(score[0]));
			check_score("model score b", 4'(sc_sb[i]), 4'(score[1]));
			check_score("score a", 4'(score[0]), dut0.score_a);
			check_score("score b", 4'(score[1]), dut0.score_b);
			check_segs("hex0", digit_segs(score[0]), hex0);
			check_segs("hex1", digit_segs(score[1]), hex1);
		end
		repeat (2) @(posedge CLOCK_50);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/tank_game_pkg.sv
hw/frame_tick.sv
hw/seg7_decoder.sv
game/player_unit.sv
game/score_keeper.sv
game/game_control.sv
video/rect_filler.sv
hw/tank_game_top.sv
verif/tank_game_checker.sv
verif/tank_game_tb.sv
